//--- vga_framebuffer.f
vga_pkg.sv
video_timing.sv
frame_buffer.sv
scan_out.sv
vga_framebuffer.sv
tb_vga_framebuffer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vga_framebuffer
FLIST     ?= vga_framebuffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_vga_framebuffer.sv
`timescale 1ns/100ps

module tb_vga_framebuffer
    import vga_pkg::*;
();

    localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL;
    localparam int NUM_FIXED   = 7;
    localparam int NUM_ENTRIES = 15;
    localparam int SEL_HSYNC   = 0;
    localparam int SEL_VSYNC   = 1;
    localparam int SEL_READY   = 2;

    // corner cases with 100/75 written twice and 0/150 past the memory
    localparam int FIX_COL [NUM_FIXED] = '{0, 199, 0, 199, 100, 100, 0};
    localparam int FIX_ROW [NUM_FIXED] = '{0, 0, 149, 149, 75, 75, 150};
    localparam int FIX_RGB [NUM_FIXED] = '{1, 2, 4, 7, 3, 5, 6};

    logic      clk_10mhz;
    logic      rst_n;
    logic      wr_valid;
    logic      wr_ready;
    pix_addr_t wr_addr;
    rgb_t      wr_rgb;
    logic      red;
    logic      green;
    logic      blue;
    logic      h_sync;
    logic      v_sync;

    int   t_addr [NUM_ENTRIES];
    int   t_rgb  [NUM_ENTRIES];
    int   t_exp  [NUM_ENTRIES];
    int   model  [FRAME_WORDS];   // expected picture
    int   shown  [FRAME_WORDS];   // colour caught on screen
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   blank_errs = 0;
    int   pix_errs = 0;
    logic aborted = 1'b0;

    // screen position rebuilt from the sync outputs alone
    int   pos_col = 0;
    int   pos_line = 0;
    int   check_left = 0;
    logic pos_ok = 1'b0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic check_armed = 1'b0;
    logic checking = 1'b0;
    logic check_done = 1'b0;

    vga_framebuffer u_vga_framebuffer (
        .clk_10mhz (clk_10mhz),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_rgb    (wr_rgb),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .h_sync    (h_sync),
        .v_sync    (v_sync)
    );

    initial begin
        clk_10mhz = 1'b0;
        forever begin
            #50 clk_10mhz = ~clk_10mhz;   // 10 MHz
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SEL_HSYNC: return h_sync;
            SEL_VSYNC: return v_sync;
            default:   return wr_ready;
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    // counts falling edges while the signal holds its level from a falling edge
    task automatic hold_count(input int sel, input logic level, input int limit,
                              input string what, output int n);
        n = 0;
        while (!aborted && probe(sel) === level) begin
            @(negedge clk_10mhz);
            n++;
            if (n > limit) begin
                $display("timeout: no %s within %0d clocks", what, limit);
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic write_pixel(input int addr, input int rgb, output int stalls);
        wr_valid = 1'b1;
        wr_addr  = pix_addr_t'(addr);
        wr_rgb   = rgb_t'(rgb);
        hold_count(SEL_READY, 1'b0, 2 * H_TOTAL, "wr_ready for a write", stalls);
        @(posedge clk_10mhz);   // transfer on this edge
        @(negedge clk_10mhz);
        wr_valid = 1'b0;
    endtask

    task automatic build_table();
        logic [31:0] seed;
        int          col [NUM_ENTRIES];
        int          row [NUM_ENTRIES];
        seed = 32'h2388;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (i < NUM_FIXED) begin
                col[i]   = FIX_COL[i];
                row[i]   = FIX_ROW[i];
                t_rgb[i] = FIX_RGB[i];
            end else begin
                seed     = next_random(seed);
                col[i]   = int'(seed % 32'(H_ACTIVE));
                seed     = next_random(seed);
                row[i]   = int'(seed % 32'(V_ACTIVE / LINE_REPEAT));
                seed     = next_random(seed);
                t_rgb[i] = int'(seed[2:0]);
            end
            t_addr[i] = col[i] + row[i] * H_ACTIVE;
        end
        // the last write to an address is what the screen shows
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            t_exp[i] = t_rgb[i];
            for (int j = i + 1; j < NUM_ENTRIES; j++) begin
                if (t_addr[j] == t_addr[i]) begin
                    t_exp[i] = t_rgb[j];
                end
            end
            if (t_addr[i] < FRAME_WORDS) begin
                model[t_addr[i]] = t_exp[i];
            end
        end
        for (int a = 0; a < FRAME_WORDS; a++) begin
            shown[a] = -1;   // never caught
        end
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        repeat (10) begin
            @(negedge clk_10mhz);
            check_value("reset outputs", 0, int'({h_sync, v_sync, red, green, blue}));
            check_value("reset wr_ready", 1, int'(wr_ready));
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk_10mhz);
            check_value("outputs after reset", 0, int'({h_sync, v_sync, red, green, blue}));
        end
        report_test("reset", errors - start);
    endtask

    task automatic sync_test();
        int start;
        int n_high;
        int n_low;
        start = errors;
        hold_count(SEL_HSYNC, 1'b0, 2 * H_TOTAL, "h_sync rise", n_low);
        for (int k = 0; k < 3; k++) begin
            hold_count(SEL_HSYNC, 1'b1, 2 * H_TOTAL, "h_sync fall", n_high);
            hold_count(SEL_HSYNC, 1'b0, 2 * H_TOTAL, "h_sync rise", n_low);
            if (!aborted) begin
                check_value("h_sync width", H_SYNC_END - H_SYNC_START, n_high);
                check_value("h_sync period", H_TOTAL, n_high + n_low);
            end
        end
        hold_count(SEL_VSYNC, 1'b0, 2 * FRAME_CLKS, "v_sync rise", n_low);
        hold_count(SEL_VSYNC, 1'b1, 2 * FRAME_CLKS, "v_sync fall", n_high);
        hold_count(SEL_VSYNC, 1'b0, 2 * FRAME_CLKS, "v_sync rise", n_low);
        if (!aborted) begin
            check_value("v_sync width", (V_SYNC_END - V_SYNC_START) * H_TOTAL, n_high);
            check_value("v_sync period", FRAME_CLKS, n_high + n_low);
        end
        report_test("sync", errors - start);
    endtask

    task automatic back_pressure_test();
        int start;
        int n_low;
        int n_high;
        start = errors;
        hold_count(SEL_READY, 1'b1, 2 * FRAME_CLKS, "first visible line", n_high);
        for (int k = 0; k < 6; k++) begin
            hold_count(SEL_READY, 1'b0, 2 * H_TOTAL, "wr_ready rise", n_low);
            hold_count(SEL_READY, 1'b1, 2 * H_TOTAL, "wr_ready fall", n_high);
            if (!aborted) begin
                check_value("wr_ready low run", H_ACTIVE, n_low);
                check_value("wr_ready high run", H_TOTAL - H_ACTIVE, n_high);
            end
        end
        report_test("back_pressure", errors - start);
    endtask

    task automatic write_test();
        int start;
        int stalls;
        int first_stalls;
        start = errors;
        first_stalls = 0;
        // first clock of a fresh low run
        hold_count(SEL_READY, 1'b0, 2 * H_TOTAL, "wr_ready rise", stalls);
        hold_count(SEL_READY, 1'b1, 2 * FRAME_CLKS, "wr_ready fall", stalls);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_pixel(t_addr[i], t_rgb[i], stalls);
            if (i == 0) begin
                first_stalls = stalls;   // raised while the scan owned the memory
            end
        end
        check_value("write held while stalled", H_ACTIVE, first_stalls);
        report_test("stall", errors - start);
    endtask

    task automatic frame_test();
        int n;
        int start;
        n = 0;
        check_armed = 1'b1;
        while (!check_done && !aborted) begin
            @(negedge clk_10mhz);
            n++;
            if (n > 3 * FRAME_CLKS) begin
                $display("timeout: the full frame check never finished");
                errors++;
                aborted = 1'b1;
            end
        end
        errors += blank_errs + pix_errs;
        report_test("blanking", blank_errs);
        report_test("pixels", pix_errs);
        start = errors;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (t_addr[i] < FRAME_WORDS) begin
                check_value($sformatf("table entry %0d", i), t_exp[i], shown[t_addr[i]]);
            end
        end
        report_test("table", errors - start);
    endtask

    // tracks the beam and compares one whole frame against the model
    always @(negedge clk_10mhz) begin : pixel_monitor
        int expv;
        int seen;
        if (hs_prev && !h_sync) begin
            pos_col = H_SYNC_END;
        end else begin
            pos_col = (pos_col + 1) % H_TOTAL;
            if (pos_col == 0) begin
                pos_line = (pos_line + 1) % V_TOTAL;
            end
        end
        if (vs_prev && !v_sync) begin
            pos_line = V_SYNC_END;
            pos_ok   = 1'b1;
        end
        if (check_armed && !checking && pos_ok && pos_line == V_SYNC_END && pos_col == 0) begin
            checking   = 1'b1;
            check_left = FRAME_CLKS;
        end
        if (checking) begin
            seen = int'({blue, green, red});
            if (pos_col < H_ACTIVE && pos_line < V_ACTIVE) begin
                expv = model[(pos_line / LINE_REPEAT) * H_ACTIVE + pos_col];
                shown[(pos_line / LINE_REPEAT) * H_ACTIVE + pos_col] = seen;
                assert (seen == expv) else begin
                    $display("CHECK FAILED pixels at column %0d line %0d: expected %0d, actual %0d",
                             pos_col, pos_line, expv, seen);
                    pix_errs++;
                end
            end else begin
                assert (seen == 0) else begin
                    $display("CHECK FAILED blanking at column %0d line %0d: expected 0, actual %0d",
                             pos_col, pos_line, seen);
                    blank_errs++;
                end
            end
            check_left--;
            if (check_left == 0) begin
                checking    = 1'b0;
                check_armed = 1'b0;
                check_done  = 1'b1;
            end
        end
        hs_prev = h_sync;
        vs_prev = v_sync;
    end

    initial begin
        rst_n    = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_rgb   = '0;
        build_table();
        reset_test();
        sync_test();
        back_pressure_test();
        write_test();
        frame_test();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vga_framebuffer.sv
`timescale 1ns/100ps

module vga_framebuffer
    import vga_pkg::*;
#(
    parameter int H_ACTIVE     = vga_pkg::H_ACTIVE,
    parameter int H_SYNC_START = vga_pkg::H_SYNC_START,
    parameter int H_SYNC_END   = vga_pkg::H_SYNC_END,
    parameter int H_TOTAL      = vga_pkg::H_TOTAL,
    parameter int V_ACTIVE     = vga_pkg::V_ACTIVE,
    parameter int V_SYNC_START = vga_pkg::V_SYNC_START,
    parameter int V_SYNC_END   = vga_pkg::V_SYNC_END,
    parameter int V_TOTAL      = vga_pkg::V_TOTAL,
    parameter int LINE_REPEAT  = vga_pkg::LINE_REPEAT,
    parameter int FRAME_WORDS  = vga_pkg::FRAME_WORDS
) (
    input  logic      clk_10mhz,
    input  logic      rst_n,
    // host write port
    input  logic      wr_valid,
    output logic      wr_ready,
    input  pix_addr_t wr_addr,
    input  rgb_t      wr_rgb,
    // video
    output logic      red,
    output logic      green,
    output logic      blue,
    output logic      h_sync,
    output logic      v_sync
);

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       active;
    logic       h_sync_raw;
    logic       v_sync_raw;
    logic       rd_en;
    pix_addr_t  rd_addr;
    rgb_t       rd_rgb;

    video_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .H_TOTAL      (H_TOTAL),
        .V_ACTIVE     (V_ACTIVE),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END),
        .V_TOTAL      (V_TOTAL)
    ) u_video_timing (
        .clk_10mhz  (clk_10mhz),
        .rst_n      (rst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .active     (active),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw)
    );

    scan_out #(
        .H_ACTIVE    (H_ACTIVE),
        .LINE_REPEAT (LINE_REPEAT)
    ) u_scan_out (
        .clk_10mhz  (clk_10mhz),
        .rst_n      (rst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .active     (active),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_rgb     (rd_rgb),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    frame_buffer #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_frame_buffer (
        .clk_10mhz (clk_10mhz),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_rgb    (rd_rgb),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_rgb    (wr_rgb)
    );

endmodule

//--- scan_out.sv
`timescale 1ns/100ps

module scan_out
    import vga_pkg::*;
#(
    parameter int H_ACTIVE    = vga_pkg::H_ACTIVE,
    parameter int LINE_REPEAT = vga_pkg::LINE_REPEAT
) (
    input  logic       clk_10mhz,
    input  logic       rst_n,
    input  logic [9:0] h_count,
    input  logic [9:0] v_count,
    input  logic       active,
    input  logic       h_sync_raw,
    input  logic       v_sync_raw,
    // memory port
    output logic       rd_en,
    output pix_addr_t  rd_addr,
    input  rgb_t       rd_rgb,
    // video out
    output logic       red,
    output logic       green,
    output logic       blue,
    output logic       h_sync,
    output logic       v_sync
);

    localparam int LR_W = $clog2(LINE_REPEAT + 1);

    pix_addr_t       row_base;      // address of column 0 on this stored row
    logic [LR_W-1:0] line_in_row;   // scan lines already shown of this row
    pix_addr_t       base_now;
    logic [LR_W-1:0] lr_now;
    logic            first_line;
    logic            line_done;

    // delay line for active and syncs
    logic act_d2;
    logic hs_d1;
    logic hs_d2;
    logic vs_d1;
    logic vs_d2;

    // line 0 restarts the row walk, so the frame wrap clears it
    assign first_line = (v_count == '0);
    assign base_now   = first_line ? '0 : row_base;
    assign lr_now     = first_line ? '0 : line_in_row;

    assign line_done = active && (h_count == 10'(H_ACTIVE - 1));

    // row walk by addition only
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            row_base    <= '0;
            line_in_row <= '0;
        end else if (line_done) begin
            if (lr_now == LR_W'(LINE_REPEAT - 1)) begin
                row_base    <= base_now + pix_addr_t'(H_ACTIVE);   // next stored row
                line_in_row <= '0;
            end else begin
                row_base    <= base_now;
                line_in_row <= lr_now + 1'b1;
            end
        end
    end

    // stage 1: read request
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            rd_en <= 1'b0;
            hs_d1 <= 1'b0;
            vs_d1 <= 1'b0;
        end else begin
            rd_en <= active;   // doubles as the first active delay
            hs_d1 <= h_sync_raw;
            vs_d1 <= v_sync_raw;
        end
    end

    always_ff @(posedge clk_10mhz) begin
        rd_addr <= base_now + pix_addr_t'(h_count);
    end

    // stage 2: memory answers, flags follow along
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            act_d2 <= 1'b0;
            hs_d2  <= 1'b0;
            vs_d2  <= 1'b0;
        end else begin
            act_d2 <= rd_en;
            hs_d2  <= hs_d1;
            vs_d2  <= vs_d1;
        end
    end

    // stage 3: blank outside the visible area
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            red    <= 1'b0;
            green  <= 1'b0;
            blue   <= 1'b0;
            h_sync <= 1'b0;
            v_sync <= 1'b0;
        end else begin
            red    <= act_d2 & rd_rgb[0];
            green  <= act_d2 & rd_rgb[1];
            blue   <= act_d2 & rd_rgb[2];
            h_sync <= hs_d2;
            v_sync <= vs_d2;
        end
    end

    // row walk must stay inside the memory the top level sized
    a_addr_range: assert property (
        @(posedge clk_10mhz) disable iff (!rst_n)
        rd_en |-> (32'(rd_addr) < FRAME_WORDS)
    );

endmodule

//--- frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer
    import vga_pkg::*;
#(
    parameter int FRAME_WORDS = vga_pkg::FRAME_WORDS
) (
    input  logic      clk_10mhz,
    input  logic      rst_n,
    // scan side
    input  logic      rd_en,
    input  pix_addr_t rd_addr,
    output rgb_t      rd_rgb,
    // host side
    input  logic      wr_valid,
    output logic      wr_ready,
    input  pix_addr_t wr_addr,
    input  rgb_t      wr_rgb
);

    rgb_t mem [FRAME_WORDS];

    logic wr_fire;
    logic wr_in_range;
    logic mem_we;

    // picture starts black
    initial begin
        for (int i = 0; i < FRAME_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // the scan read always wins the single port
    assign wr_ready = !rd_en;

    assign wr_fire     = wr_valid && wr_ready;
    assign wr_in_range = (32'(wr_addr) < FRAME_WORDS);
    assign mem_we      = wr_fire && wr_in_range;   // out of range is taken but dropped

    always_ff @(posedge clk_10mhz) begin
        if (mem_we) begin
            mem[wr_addr] <= wr_rgb;
        end
    end

    // read data one clock after rd_en
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            rd_rgb <= '0;
        end else if (rd_en) begin
            rd_rgb <= mem[rd_addr];
        end
    end

    // a pending write leaves its word untouched while the scan reads
    a_no_collision: assert property (
        @(posedge clk_10mhz) disable iff (!rst_n)
        rd_en && wr_valid && wr_in_range |=> mem[$past(wr_addr)] == $past(mem[wr_addr])
    );

endmodule

//--- video_timing.sv
`timescale 1ns/100ps

module video_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE     = vga_pkg::H_ACTIVE,
    parameter int H_SYNC_START = vga_pkg::H_SYNC_START,
    parameter int H_SYNC_END   = vga_pkg::H_SYNC_END,
    parameter int H_TOTAL      = vga_pkg::H_TOTAL,
    parameter int V_ACTIVE     = vga_pkg::V_ACTIVE,
    parameter int V_SYNC_START = vga_pkg::V_SYNC_START,
    parameter int V_SYNC_END   = vga_pkg::V_SYNC_END,
    parameter int V_TOTAL      = vga_pkg::V_TOTAL
) (
    input  logic       clk_10mhz,
    input  logic       rst_n,
    output logic [9:0] h_count,
    output logic [9:0] v_count,
    output logic       active,
    output logic       h_sync_raw,
    output logic       v_sync_raw
);

    localparam logic [9:0] H_LAST = 10'(H_TOTAL - 1);
    localparam logic [9:0] V_LAST = 10'(V_TOTAL - 1);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (h_count == H_LAST);
    assign v_wrap = (v_count == V_LAST);

    // line counter steps every clock, frame counter on line wrap
    always_ff @(posedge clk_10mhz) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_wrap) begin
                h_count <= '0;
                if (v_wrap) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 10'd1;
                end
            end else begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    // visible window
    assign active = (h_count < 10'(H_ACTIVE)) && (v_count < 10'(V_ACTIVE));

    // sync windows, start inclusive and end exclusive
    assign h_sync_raw = (h_count >= 10'(H_SYNC_START)) && (h_count < 10'(H_SYNC_END));
    assign v_sync_raw = (v_count >= 10'(V_SYNC_START)) && (v_count < 10'(V_SYNC_END));

    // counters must never leave their ranges, even across many frames
    a_h_range: assert property (
        @(posedge clk_10mhz) disable iff (!rst_n)
        h_count < 10'(H_TOTAL)
    );

    a_v_range: assert property (
        @(posedge clk_10mhz) disable iff (!rst_n)
        v_count < 10'(V_TOTAL)
    );

endmodule

//--- vga_pkg.sv
package vga_pkg;

    // one bit per gun: red in bit 0, green in bit 1, blue in bit 2
    typedef logic [2:0] rgb_t;

    // column plus stored row times H_ACTIVE
    typedef logic [14:0] pix_addr_t;

    // horizontal timing in pixel clocks
    localparam int H_ACTIVE     = 200;
    localparam int H_SYNC_START = 210;
    localparam int H_SYNC_END   = 242;   // first clock after sync
    localparam int H_TOTAL      = 265;

    // vertical timing in lines
    localparam int V_ACTIVE     = 600;
    localparam int V_SYNC_START = 601;
    localparam int V_SYNC_END   = 605;   // first line after sync
    localparam int V_TOTAL      = 629;

    // each stored row is shown on this many scan lines
    localparam int LINE_REPEAT  = 4;

    // pixel memory depth
    localparam int FRAME_WORDS  = H_ACTIVE * V_ACTIVE / LINE_REPEAT;

endpackage
